// File: debugPkg.sv
package debugPkg;

	// host register addresses on the 3-bit byte bus.
	localparam logic [2:0] regStatus    = 3'd0; // busy, overrun, capture and op readback.
	localparam logic [2:0] regCmd       = 3'd1; // command byte for the operand multiplexer.
	localparam logic [2:0] regMal       = 3'd2; // memory address, low byte.
	localparam logic [2:0] regMah       = 3'd3; // memory address, high byte.
	localparam logic [2:0] regMdl       = 3'd4; // memory data, low byte.
	localparam logic [2:0] regMdh       = 3'd5; // memory data, high byte, starts the write.
	localparam logic [2:0] regProbe     = 3'd6; // write snapshots a probe, read gives the low byte.
	localparam logic [2:0] regProbeHigh = 3'd7; // read gives the high byte of the snapshot.

	// op codes in the top three bits of the command byte.
	localparam logic [2:0] opNone = 3'd0; // no debug override, the CPU runs its own operands.
	localparam logic [2:0] opReg  = 3'd1; // the operand comes from a register file entry.
	localparam logic [2:0] opPc   = 3'd2; // the program counter select is driven.
	localparam logic [2:0] opCc   = 3'd3; // the condition code select is driven.

	// probe selects, taken from wdata bits 1 to 0 of a regProbe write.
	localparam logic [1:0] probeDin  = 2'd0; // data bus input.
	localparam logic [1:0] probeRegA = 2'd1; // register file port A.
	localparam logic [1:0] probeCc   = 2'd2; // condition codes.
	localparam logic [1:0] probePc   = 2'd3; // next program counter value.

	// states of the four-phase memory write requester.
	localparam logic [1:0] reqIdle    = 2'd0; // nothing in flight.
	localparam logic [1:0] reqWait    = 2'd1; // memReq is high, waiting for memAck.
	localparam logic [1:0] reqRelease = 2'd2; // memReq is low, waiting for memAck to drop.

	typedef struct packed {
		logic [2:0] addr;  // register address.
		logic [7:0] wdata; // write byte.
		logic       rd;    // single-cycle read strobe.
		logic       wr;    // single-cycle write strobe.
	} hostBus_s;

	// command byte as seen by a register operation.
	typedef struct packed {
		logic [2:0] op;
		logic       spare;
		logic [3:0] regx;
	} cmdReg_s;

	// command byte as seen by a program counter or condition code operation.
	typedef struct packed {
		logic [2:0] op;
		logic       spare;
		logic [1:0] pcx;
		logic [1:0] ccx;
	} cmdFlow_s;

	// the op field sits in the same place in both views.
	typedef union packed {
		cmdReg_s  regView;
		cmdFlow_s flowView;
	} debugCmd_u;

	typedef struct packed {
		logic [15:0] din;  // data bus input.
		logic [15:0] regA; // register file port A.
		logic [15:0] cc;   // condition codes.
		logic [15:0] pc;   // next program counter.
	} probeSet_s;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
	} memWrite_s;

	typedef struct packed {
		logic busy;
		logic overrun;
		logic captureValid;
	} statusFlags_s;

endpackage

// File: debugPort.f
debugPkg.sv
hostRegisters.sv
probeCapture.sv
debugReadback.sv
debugPort.sv
memResponder.sv
debugPortTb.sv

// File: debugPort.sv
`timescale 1ns/1ps

module debugPort import debugPkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  hostBus_s    bus,
	output logic [7:0]  rdata,
	input  probeSet_s   probes,
	output logic        memReq,
	input  logic        memAck,
	output memWrite_s   memWrite,
	output logic [2:0]  opx,
	output logic [3:0]  regx,
	output logic [1:0]  pcx,
	output logic [1:0]  ccx
);

	debugCmd_u    cmd;
	statusFlags_s flags;
	logic [15:0]  memAddr;
	logic [15:0]  captured;
	logic         captureValid;
	logic         statusRead;

	hostRegisters hostRegisters_i (
		.CLK(CLK), .RESET(RESET), .bus(bus), .statusRead(statusRead),
		.memAck(memAck), .memReq(memReq), .memWrite(memWrite),
		.memAddr(memAddr), .cmd(cmd), .flags(flags)
	);

	probeCapture probeCapture_i (
		.CLK(CLK), .RESET(RESET), .bus(bus), .probes(probes),
		.captured(captured), .captureValid(captureValid)
	);

	debugReadback debugReadback_i (
		.CLK(CLK), .RESET(RESET), .bus(bus), .flags(flags),
		.captureValid(captureValid), .memAddr(memAddr), .cmd(cmd),
		.captured(captured), .rdata(rdata), .statusRead(statusRead)
	);

	// the op picks which view of the command byte reaches the CPU.
	always_comb begin
		opx = cmd.regView.op;
		regx = 4'h0;
		pcx = 2'b00;
		ccx = 2'b00;
		if (cmd.regView.op == opReg) begin
			regx = cmd.regView.regx;
		end
		if ((cmd.flowView.op == opPc) || (cmd.flowView.op == opCc)) begin
			pcx = cmd.flowView.pcx; // both flow selects travel together.
			ccx = cmd.flowView.ccx;
		end
	end

endmodule

// File: debugPortTb.sv
`timescale 1ns/1ps

module debugPortTb import debugPkg::*; ();

	logic        CLK;
	logic        RESET;
	hostBus_s    bus;
	probeSet_s   probes;
	logic [7:0]  rdata;
	logic        memReq;
	logic        memAck;
	memWrite_s   memWrite;
	logic [2:0]  opx;
	logic [3:0]  regx;
	logic [1:0]  pcx;
	logic [1:0]  ccx;
	logic [3:0]  ackDelay;
	memWrite_s   logged;
	logic        logPulse;
	logic [7:0]  writeCount;
	logic        resetCheck;
	logic        rdCheck;
	logic        selCheck;
	logic        countCheck;
	logic [7:0]  expRd;
	logic [10:0] expSel;
	logic [7:0]  expCount;
	memWrite_s   expWrite;
	logic [31:0] rngState;
	logic [7:0]  lastCmd;
	string       testName;
	int          errorCount;
	int          testErrors;
	int          testCount;
	int          failedCount;

	debugPort dut_i (
		.CLK(CLK), .RESET(RESET), .bus(bus), .rdata(rdata), .probes(probes),
		.memReq(memReq), .memAck(memAck), .memWrite(memWrite),
		.opx(opx), .regx(regx), .pcx(pcx), .ccx(ccx)
	);

	memResponder memResponder_i (
		.CLK(CLK), .RESET(RESET), .memReq(memReq), .memWrite(memWrite), .ackDelay(ackDelay),
		.memAck(memAck), .logged(logged), .logPulse(logPulse), .writeCount(writeCount)
	);

	always #2 CLK = ~CLK; // 4 ns period.

	// every check enable is raised for one cycle by the stimulus below.
	resetState: assert property (@(posedge CLK)
		resetCheck |-> rdata == 8'h00 && !memReq && opx == opNone)
		else begin
			errorCount++;
			$display("Mismatch %s: expected %h, actual %h", testName, {8'h00, 1'b0, opNone},
				{$sampled(rdata), $sampled(memReq), $sampled(opx)});
		end
	readByte: assert property (@(posedge CLK) rdCheck |-> rdata == expRd)
		else begin
			errorCount++;
			$display("Mismatch %s: expected %h, actual %h", testName, expRd, $sampled(rdata));
		end
	cpuSelects: assert property (@(posedge CLK) selCheck |-> {opx, regx, pcx, ccx} == expSel)
		else begin
			errorCount++;
			$display("Mismatch %s: expected %h, actual %h", testName, expSel,
				{$sampled(opx), $sampled(regx), $sampled(pcx), $sampled(ccx)});
		end
	memoryWord: assert property (@(posedge CLK) logPulse |-> logged == expWrite)
		else begin
			errorCount++;
			$display("Mismatch %s: expected %h, actual %h", testName, expWrite, $sampled(logged));
		end
	writeTotal: assert property (@(posedge CLK) countCheck |-> writeCount == expCount)
		else begin
			errorCount++;
			$display("Mismatch %s: expected %0d, actual %0d", testName, expCount,
				$sampled(writeCount));
		end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// op in bits 7 to 5, the register field or the two flow fields in bits 3 to 0.
	function automatic logic [10:0] expectSelects(input logic [7:0] b);
		logic [3:0] regSel;
		logic [3:0] flowSel;
		regSel = (b[7:5] == opReg) ? b[3:0] : 4'h0;
		flowSel = (b[7:5] == opPc || b[7:5] == opCc) ? b[3:0] : 4'h0;
		return {b[7:5], regSel, flowSel};
	endfunction

	function automatic logic [7:0] statusByte(input logic [2:0] op, input logic busy,
		input logic overrun, input logic capt);
		return {op, 2'b00, busy, overrun, capt};
	endfunction

	task automatic drawRandom(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	task automatic hostWrite(input logic [2:0] addr, input logic [7:0] data);
		@(posedge CLK);
		bus <= '{addr: addr, wdata: data, rd: 1'b0, wr: 1'b1};
		@(posedge CLK);
		bus <= '0; // the register changed at this edge.
	endtask

	task automatic hostRead(input logic [2:0] addr, input logic [7:0] expected);
		@(posedge CLK);
		bus <= '{addr: addr, wdata: 8'h00, rd: 1'b1, wr: 1'b0};
		@(posedge CLK);
		bus <= '0;
		expRd <= expected;
		rdCheck <= 1'b1; // rdata is sampled one edge later.
		@(posedge CLK);
		rdCheck <= 1'b0;
	endtask

	task automatic checkSelects(input logic [10:0] expected);
		@(posedge CLK);
		expSel <= expected;
		selCheck <= 1'b1;
		@(posedge CLK);
		selCheck <= 1'b0;
	endtask

	task automatic checkCount(input logic [7:0] expected);
		@(posedge CLK);
		expCount <= expected;
		countCheck <= 1'b1;
		@(posedge CLK);
		countCheck <= 1'b0;
	endtask

	// the probe word of the chosen select, as it stood at the capture edge.
	task automatic captureProbe(input logic [1:0] sel, input logic [63:0] wide,
		output logic [15:0] expected);
		@(posedge CLK);
		probes <= wide;
		bus <= '{addr: regProbe, wdata: {6'd0, sel}, rd: 1'b0, wr: 1'b1};
		@(posedge CLK);
		bus <= '0;
		probes <= ~wide; // the snapshot must not follow this.
		expected = wide[63 - 16 * sel -: 16];
	endtask

	// returns at the edge where busy falls.
	task automatic waitForWrite(input logic [7:0] target);
		int cycles;
		cycles = 0;
		while (!(writeCount == target && !memReq && !memAck) && cycles < 100) begin
			@(posedge CLK);
			cycles++;
		end
		if (cycles >= 100) begin
			errorCount++;
			$display("%s: memory write %0d did not complete in 100 cycles", testName, target);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = errorCount;
	endtask

	task automatic finishTest();
		@(negedge CLK); // assertions of the last edge have reported by now.
		testCount++;
		if (errorCount == testErrors) begin
			$display("%s: ok", testName);
		end else begin
			failedCount++;
			$display("%s: failed with %0d errors", testName, errorCount - testErrors);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] data;
		logic [63:0] wide;
		CLK = 1'b0;
		RESET = 1'b1;
		bus = '0;
		probes = '0;
		ackDelay = 4'd0;
		resetCheck = 1'b0;
		rdCheck = 1'b0;
		selCheck = 1'b0;
		countCheck = 1'b0;
		expRd = '0;
		expSel = '0;
		expCount = '0;
		expWrite = '0;
		rngState = 32'd14;
		errorCount = 0;
		testCount = 0;
		failedCount = 0;
		testErrors = 0;
		repeat (3) @(posedge CLK);
		RESET <= 1'b0;

		startTest("reset");
		@(posedge CLK);
		resetCheck <= 1'b1;
		@(posedge CLK);
		resetCheck <= 1'b0;
		hostRead(regStatus, 8'h00);
		finishTest();

		startTest("command");
		for (int i = 0; i < 8; i++) begin
			drawRandom(r);
			lastCmd = {3'(i % 4), r[4:0]}; // walks through all four ops twice.
			hostWrite(regCmd, lastCmd);
			checkSelects(expectSelects(lastCmd));
			hostRead(regCmd, lastCmd);
		end
		finishTest();

		startTest("memory");
		hostWrite(regMal, 8'hFE);
		hostWrite(regMah, 8'h00);
		hostRead(regMal, 8'hFE);
		hostRead(regMah, 8'h00);
		for (int i = 0; i < 3; i++) begin
			drawRandom(r);
			data = r[15:0];
			hostWrite(regMdl, data[7:0]);
			ackDelay <= {1'b0, r[18:16]};
			expWrite <= '{addr: 16'h00FE + 16'(i), data: data}; // crosses into 0100.
			hostWrite(regMdh, data[15:8]);
			waitForWrite(8'(i + 1));
		end
		hostRead(regMal, 8'h01);
		hostRead(regMah, 8'h01);
		finishTest();

		startTest("probe");
		for (int sel = 0; sel < 4; sel++) begin
			drawRandom(r);
			wide[63:32] = r;
			drawRandom(r);
			wide[31:0] = r;
			captureProbe(2'(sel), wide, data);
			hostRead(regProbe, data[7:0]);
			hostRead(regProbeHigh, data[15:8]);
		end
		hostRead(regStatus, statusByte(lastCmd[7:5], 1'b0, 1'b0, 1'b1));
		finishTest();

		startTest("overrun");
		hostWrite(regMdl, 8'hA5);
		ackDelay <= 4'd9; // long stall keeps busy high for the second write.
		expWrite <= '{addr: 16'h0101, data: 16'h5AA5};
		hostWrite(regMdh, 8'h5A);
		hostWrite(regMdh, 8'hC3);
		waitForWrite(8'd4);
		ackDelay <= 4'd0; // a second write kept back by the port would now land at once.
		hostRead(regStatus, statusByte(lastCmd[7:5], 1'b0, 1'b1, 1'b1));
		hostRead(regStatus, statusByte(lastCmd[7:5], 1'b0, 1'b0, 1'b1));
		checkCount(8'd4);
		finishTest();

		$display("tests %0d, failed %0d, errors %0d", testCount, failedCount, errorCount);
		if (errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: debugReadback.sv
`timescale 1ns/1ps

module debugReadback import debugPkg::*; (
	input  logic         CLK,
	input  logic         RESET,
	input  hostBus_s     bus,
	input  statusFlags_s flags,
	input  logic         captureValid,
	input  logic [15:0]  memAddr,
	input  debugCmd_u    cmd,
	input  logic [15:0]  captured,
	output logic [7:0]   rdata,
	output logic         statusRead
);

	logic [7:0] readByte;

	assign statusRead = bus.rd && (bus.addr == regStatus); // clears overrun at the same edge.

	// read multiplexer by register address.
	always_comb begin
		case (bus.addr)
			regStatus: begin
				readByte = {cmd.regView.op, 2'b00, flags.busy, flags.overrun, captureValid};
			end
			regCmd:       readByte = cmd; // the byte as written.
			regMal:       readByte = memAddr[7:0];
			regMah:       readByte = memAddr[15:8];
			regMdl:       readByte = 8'h00; // data bytes are write only.
			regMdh:       readByte = 8'h00;
			regProbe:     readByte = captured[7:0];
			regProbeHigh: readByte = captured[15:8];
			default:      readByte = 8'h00;
		endcase
	end

	// the read byte is held until the next read strobe.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rdata <= 8'h00;
		end else if (bus.rd) begin
			rdata <= readByte;
		end
	end

	// the host never reads and writes in the same cycle.
	strobesExclusive: assert property (@(posedge CLK) disable iff (RESET)
		!(bus.rd && bus.wr));

endmodule

// File: hostRegisters.sv
`timescale 1ns/1ps

module hostRegisters import debugPkg::*; (
	input  logic         CLK,
	input  logic         RESET,
	input  hostBus_s     bus,
	input  logic         statusRead, // pulses when the host reads regStatus.
	input  logic         memAck,
	output logic         memReq,
	output memWrite_s    memWrite,
	output logic [15:0]  memAddr,
	output debugCmd_u    cmd,
	output statusFlags_s flags
);

	logic       cmdWrite;
	logic       malWrite;
	logic       mahWrite;
	logic       mdlWrite;
	logic       mdhWrite;
	logic       launch;
	logic       done;
	logic       busy;
	logic       overrun;
	logic [1:0] reqState;
	logic [7:0] mdlByte;

	assign cmdWrite = bus.wr && (bus.addr == regCmd); // one strobe per target register.
	assign malWrite = bus.wr && (bus.addr == regMal);
	assign mahWrite = bus.wr && (bus.addr == regMah);
	assign mdlWrite = bus.wr && (bus.addr == regMdl);
	assign mdhWrite = bus.wr && (bus.addr == regMdh);

	assign busy   = (reqState != reqIdle); // high from the rise of memReq to the fall of memAck.
	assign launch = mdhWrite && !busy; // a high byte write starts a memory write when idle.
	assign done   = (reqState == reqRelease) && !memAck; // last phase of the handshake.

	// the command register drives the CPU selects directly.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			cmd <= '0; // a zero command decodes as opNone.
		end else if (cmdWrite) begin
			cmd <= bus.wdata;
		end
	end

	// address counter, loaded a byte at a time and stepped once per completed write.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			memAddr <= '0;
		end else if (malWrite) begin
			memAddr[7:0] <= bus.wdata;
		end else if (mahWrite) begin
			memAddr[15:8] <= bus.wdata;
		end else if (done) begin
			memAddr <= memAddr + 16'd1; // carry into the high byte, wraps at 16 bits.
		end
	end

	always_ff @(posedge CLK) begin
		if (mdlWrite) begin
			mdlByte <= bus.wdata; // held until the high byte arrives.
		end
	end

	// the outgoing word is frozen at launch, so later host writes can not disturb it.
	always_ff @(posedge CLK) begin
		if (launch) begin
			memWrite.addr <= memAddr;
			memWrite.data <= {bus.wdata, mdlByte};
		end
	end

	// four-phase requester.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			reqState <= reqIdle;
			memReq   <= 1'b0;
		end else begin
			case (reqState)
				reqIdle: begin
					if (launch) begin
						memReq   <= 1'b1; // memAck is already low here.
						reqState <= reqWait;
					end
				end
				reqWait: begin
					if (memAck) begin
						memReq   <= 1'b0; // third phase.
						reqState <= reqRelease;
					end
				end
				reqRelease: begin
					if (!memAck) begin
						reqState <= reqIdle; // busy falls on this edge.
					end
				end
				default: begin
					memReq   <= 1'b0;
					reqState <= reqIdle;
				end
			endcase
		end
	end

	// sticky overrun, cleared only by a status read.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			overrun <= 1'b0;
		end else if (mdhWrite && busy) begin
			overrun <= 1'b1; // the write is dropped.
		end else if (statusRead) begin
			overrun <= 1'b0;
		end
	end

	assign flags = '{busy: busy, overrun: overrun, captureValid: 1'b0}; // capture flag lives elsewhere.

	// the memory side must see a steady word for the whole handshake.
	memWriteStable: assert property (@(posedge CLK) disable iff (RESET)
		(memReq || memAck) && $past(memReq || memAck) |-> $stable(memWrite));

	// a new request only starts once the previous acknowledge has dropped.
	reqAfterAckLow: assert property (@(posedge CLK) disable iff (RESET)
		$rose(memReq) |-> !$past(memAck));

endmodule

// File: memResponder.sv
`timescale 1ns/1ps

module memResponder import debugPkg::*; (
	input  logic       CLK,
	input  logic       RESET,
	input  logic       memReq,
	input  memWrite_s  memWrite,
	input  logic [3:0] ackDelay,   // cycles of stall before the acknowledge.
	output logic       memAck,
	output memWrite_s  logged,     // last write the memory accepted.
	output logic       logPulse,   // one cycle after each accepted write.
	output logic [7:0] writeCount
);

	logic [3:0] waitCount;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			memAck     <= 1'b0;
			logPulse   <= 1'b0;
			waitCount  <= '0;
			writeCount <= '0;
			logged     <= '0;
		end else begin
			logPulse <= 1'b0;
			if (memReq && !memAck) begin
				if (waitCount >= ackDelay) begin
					memAck     <= 1'b1; // second phase, the word is taken here.
					logged     <= memWrite;
					logPulse   <= 1'b1;
					writeCount <= writeCount + 8'd1;
					waitCount  <= '0;
				end else begin
					waitCount <= waitCount + 4'd1; // the memory stalls.
				end
			end else if (!memReq && memAck) begin
				memAck <= 1'b0; // fourth phase follows the request drop at once.
			end
		end
	end

endmodule

// File: probeCapture.sv
`timescale 1ns/1ps

module probeCapture import debugPkg::*; (
	input  logic        CLK,
	input  logic        RESET,
	input  hostBus_s    bus,
	input  probeSet_s   probes,
	output logic [15:0] captured,
	output logic        captureValid
);

	logic        captureWrite;
	logic [15:0] selected;

	assign captureWrite = bus.wr && (bus.addr == regProbe); // the written byte carries the select.

	// probe multiplexer, steered by the select in the write byte.
	always_comb begin
		case (bus.wdata[1:0])
			probeDin:  selected = probes.din;
			probeRegA: selected = probes.regA;
			probeCc:   selected = probes.cc;
			probePc:   selected = probes.pc;
			default:   selected = probes.din;
		endcase
	end

	// snapshot so both byte reads come from the same sample.
	always_ff @(posedge CLK) begin
		if (captureWrite) begin
			captured <= selected;
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			captureValid <= 1'b0;
		end else if (captureWrite) begin
			captureValid <= 1'b1; // stays set until the next reset.
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module debugPortTb \
	-f debugPort.f -o debugPortSim
./obj_dir/debugPortSim | tee sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
else
	exit 1
fi
